//--- rtl/csr_defs.svh
`ifndef CSR_DEFS_SVH
`define CSR_DEFS_SVH

// machine word of the core
`define CSR_XLEN 32

// csr address space
`define CSR_ADDR_W 12

`endif

//--- rtl/csr_pkg.sv
`include "csr_defs.svh"

package csr_pkg;

   typedef logic [`CSR_XLEN-1:0]   csr_data_t;
   typedef logic [`CSR_ADDR_W-1:0] csr_addr_t;

   typedef enum logic [1:0] {
      CSR_NONE = 2'd0,
      CSR_RW   = 2'd1,
      CSR_RS   = 2'd2,
      CSR_RC   = 2'd3
   } csr_op_e;

   typedef enum logic {
      R_IDLE    = 1'b0,
      R_PENDING = 1'b1
   } redir_state_e;

   typedef struct packed {
      csr_op_e   op;
      csr_addr_t addr;
      csr_data_t operand;
   } csr_req_t;

   typedef struct packed {
      logic      we;
      csr_addr_t addr;
      csr_data_t data;
   } csr_wr_t;

   typedef struct packed {
      csr_data_t target;
      logic      is_trap;   // 0 on mret
   } redirect_t;

   typedef struct packed {
      csr_data_t mstatus;
      csr_data_t mie;
      csr_data_t mtvec;
      csr_data_t mepc;
      csr_data_t mcause;
      csr_data_t mip;
   } csr_file_t;

   localparam csr_addr_t MSTATUS_ADDR = 12'h300;
   localparam csr_addr_t MIE_ADDR     = 12'h304;
   localparam csr_addr_t MTVEC_ADDR   = 12'h305;
   localparam csr_addr_t MEPC_ADDR    = 12'h341;
   localparam csr_addr_t MCAUSE_ADDR  = 12'h342;
   localparam csr_addr_t MIP_ADDR     = 12'h344;

   localparam int MSTATUS_MIE_BIT = 3;
   localparam int MEIP_BIT        = 11;   // also meie in mie

   localparam csr_data_t MCAUSE_EXT_INTR = 32'h8000_000B;

endpackage

//--- rtl/csr_access.sv
`timescale 1ns/1ps

module csr_access (
   input  csr_pkg::csr_req_t  req_i,
   input  csr_pkg::csr_data_t rdata_i,
   output csr_pkg::csr_addr_t raddr_o,
   output csr_pkg::csr_wr_t   wr_o
);

   csr_pkg::csr_data_t set_val;
   csr_pkg::csr_data_t clr_val;
   logic               operand_zero;

   // read port sees the instruction address directly
   assign raddr_o = req_i.addr;

   assign set_val      = rdata_i | req_i.operand;
   assign clr_val      = rdata_i & ~req_i.operand;
   assign operand_zero = (req_i.operand == '0);

   always_comb begin
      wr_o.addr = req_i.addr;
      wr_o.we   = 1'b0;
      wr_o.data = req_i.operand;
      case (req_i.op)
         csr_pkg::CSR_RW: begin
            wr_o.we   = 1'b1;
            wr_o.data = req_i.operand;
         end
         csr_pkg::CSR_RS: begin
            wr_o.we   = ~operand_zero;   // csrrs with x0 only reads
            wr_o.data = set_val;
         end
         csr_pkg::CSR_RC: begin
            wr_o.we   = ~operand_zero;
            wr_o.data = clr_val;
         end
         default: begin
            wr_o.we   = 1'b0;
         end
      endcase
   end

endmodule

//--- rtl/csr_regs.sv
`timescale 1ns/1ps

module csr_regs (
   input  logic                clk_i,
   input  logic                rst_ni,
   input  csr_pkg::csr_addr_t  raddr_i,
   input  csr_pkg::csr_wr_t    wr_i,
   input  logic                e_intr_i,      // external interrupt
   input  logic                mret_i,
   input  csr_pkg::csr_data_t  pc_i,
   input  logic                intr_flag_i,
   output csr_pkg::csr_data_t  rdata_o,
   output csr_pkg::csr_file_t  file_o
);

   csr_pkg::csr_data_t mstatus_q;
   csr_pkg::csr_data_t mie_q;
   csr_pkg::csr_data_t mtvec_q;
   csr_pkg::csr_data_t mepc_q;
   csr_pkg::csr_data_t mcause_q;
   csr_pkg::csr_data_t mip_q;

   logic wr_mstatus;
   logic wr_mie;
   logic wr_mtvec;

   // only these three are writable by software
   assign wr_mstatus = wr_i.we && (wr_i.addr == csr_pkg::MSTATUS_ADDR);
   assign wr_mie     = wr_i.we && (wr_i.addr == csr_pkg::MIE_ADDR);
   assign wr_mtvec   = wr_i.we && (wr_i.addr == csr_pkg::MTVEC_ADDR);

   always_comb begin
      case (raddr_i)
         csr_pkg::MSTATUS_ADDR: rdata_o = mstatus_q;
         csr_pkg::MIE_ADDR:     rdata_o = mie_q;
         csr_pkg::MTVEC_ADDR:   rdata_o = mtvec_q;
         csr_pkg::MEPC_ADDR:    rdata_o = mepc_q;
         csr_pkg::MCAUSE_ADDR:  rdata_o = mcause_q;
         csr_pkg::MIP_ADDR:     rdata_o = mip_q;
         default:               rdata_o = '0;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         mstatus_q <= '0;
      end else if (wr_mstatus) begin
         mstatus_q <= wr_i.data;
      end else if (intr_flag_i) begin
         mstatus_q[csr_pkg::MSTATUS_MIE_BIT] <= 1'b0;   // trap entry
      end else if (mret_i) begin
         mstatus_q[csr_pkg::MSTATUS_MIE_BIT] <= 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         mie_q   <= '0;
         mtvec_q <= '0;
      end else begin
         if (wr_mie) begin
            mie_q <= wr_i.data;
         end
         if (wr_mtvec) begin
            mtvec_q <= wr_i.data;
         end
      end
   end

   // set on the interrupt edge, wins over mret
   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         mip_q <= '0;
      end else if (e_intr_i) begin
         mip_q[csr_pkg::MEIP_BIT] <= 1'b1;
      end else if (mret_i) begin
         mip_q <= '0;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         mepc_q   <= '0;
         mcause_q <= '0;
      end else if (e_intr_i) begin
         mepc_q   <= pc_i;   // pc of the interrupted instruction
         mcause_q <= csr_pkg::MCAUSE_EXT_INTR;
      end
   end

   assign file_o.mstatus = mstatus_q;
   assign file_o.mie     = mie_q;
   assign file_o.mtvec   = mtvec_q;
   assign file_o.mepc    = mepc_q;
   assign file_o.mcause  = mcause_q;
   assign file_o.mip     = mip_q;

endmodule

//--- rtl/csr_ops.sv
`timescale 1ns/1ps

module csr_ops (
   input  csr_pkg::csr_file_t  file_i,
   input  logic                mret_i,
   output logic                intr_flag_o,
   output csr_pkg::redirect_t  redir_req_o,
   output logic                redir_req_valid_o
);

   logic glb_en;
   logic ext_en;
   logic ext_pend;
   logic take_intr;

   assign glb_en   = file_i.mstatus[csr_pkg::MSTATUS_MIE_BIT];
   assign ext_en   = file_i.mie[csr_pkg::MEIP_BIT];   // meie
   assign ext_pend = file_i.mip[csr_pkg::MEIP_BIT];

   assign take_intr   = glb_en & ext_en & ext_pend;
   assign intr_flag_o = take_intr;

   // interrupt wins over a simultaneous mret
   always_comb begin
      if (take_intr) begin
         redir_req_o.target  = file_i.mtvec;   // direct mode only
         redir_req_o.is_trap = 1'b1;
      end else begin
         redir_req_o.target  = file_i.mepc;
         redir_req_o.is_trap = 1'b0;
      end
   end

   assign redir_req_valid_o = take_intr | mret_i;

endmodule

//--- rtl/trap_redirect.sv
`timescale 1ns/1ps

module trap_redirect (
   input  logic                clk_i,
   input  logic                rst_ni,
   input  csr_pkg::redirect_t  req_i,
   input  logic                req_valid_i,
   input  logic                ready_i,        // fetch accepts
   output csr_pkg::redirect_t  redirect_o,
   output logic                valid_o
);

   csr_pkg::redir_state_e state_q;
   csr_pkg::redir_state_e state_d;
   csr_pkg::redirect_t    hold_q;
   logic                  capture;

   assign capture = (state_q == csr_pkg::R_IDLE) && req_valid_i;

   always_comb begin
      state_d = state_q;
      case (state_q)
         csr_pkg::R_IDLE: begin
            if (req_valid_i) begin
               state_d = csr_pkg::R_PENDING;
            end
         end
         csr_pkg::R_PENDING: begin
            if (ready_i) begin
               state_d = csr_pkg::R_IDLE;   // transfer at this edge
            end
         end
         default: begin
            state_d = csr_pkg::R_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_ni) begin
         state_q <= csr_pkg::R_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   // held stable while pending, new requests dropped
   always_ff @(posedge clk_i) begin
      if (capture) begin
         hold_q <= req_i;
      end
   end

   assign redirect_o = hold_q;
   assign valid_o    = (state_q == csr_pkg::R_PENDING);

endmodule

//--- rtl/csr_unit_top.sv
`timescale 1ns/1ps

module csr_unit_top (
   input  logic                clk_i,
   input  logic                rst_ni,
   input  csr_pkg::csr_req_t   csr_req_i,
   input  csr_pkg::csr_data_t  pc_i,
   input  logic                e_intr_i,
   input  logic                mret_i,
   input  logic                redirect_ready_i,
   output csr_pkg::csr_data_t  csr_rdata_o,
   output csr_pkg::redirect_t  redirect_o,
   output logic                redirect_valid_o
);

   csr_pkg::csr_addr_t raddr;
   csr_pkg::csr_wr_t   wr;
   csr_pkg::csr_data_t rdata;
   csr_pkg::csr_file_t csr_file;
   csr_pkg::redirect_t redir_req;
   logic               redir_req_valid;
   logic               intr_flag;

   csr_access csr_access_i (
      .req_i   (csr_req_i),
      .rdata_i (rdata),
      .raddr_o (raddr),
      .wr_o    (wr)
   );

   csr_regs csr_regs_i (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .raddr_i     (raddr),
      .wr_i        (wr),
      .e_intr_i    (e_intr_i),
      .mret_i      (mret_i),
      .pc_i        (pc_i),
      .intr_flag_i (intr_flag),
      .rdata_o     (rdata),
      .file_o      (csr_file)
   );

   csr_ops csr_ops_i (
      .file_i            (csr_file),
      .mret_i            (mret_i),
      .intr_flag_o       (intr_flag),
      .redir_req_o       (redir_req),
      .redir_req_valid_o (redir_req_valid)
   );

   trap_redirect trap_redirect_i (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .req_i       (redir_req),
      .req_valid_i (redir_req_valid),
      .ready_i     (redirect_ready_i),
      .redirect_o  (redirect_o),
      .valid_o     (redirect_valid_o)
   );

   assign csr_rdata_o = rdata;

endmodule

//--- testbench/csr_unit_assertions.sv
`timescale 1ns/1ps

module csr_unit_assertions (
   input logic               clk_i,
   input logic               rst_ni,
   input csr_pkg::redirect_t req_i,
   input logic               req_valid_i,
   input logic               ready_i,
   input csr_pkg::redirect_t redirect_i,
   input logic               valid_i
);

   // valid stays up until fetch takes the redirect
   valid_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
      valid_i && !ready_i |=> valid_i)
      else $error("redirect valid dropped before it was accepted");

   stable_target: assert property (@(posedge clk_i) disable iff (!rst_ni)
      valid_i && !ready_i |=> $stable(redirect_i))
      else $error("redirect payload changed while waiting for ready");

   // a return request only comes from mret
   no_mret_pending: assert property (@(posedge clk_i) disable iff (!rst_ni)
      valid_i |-> !(req_valid_i && !req_i.is_trap))
      else $error("mret arrived while a redirect was pending");

endmodule

//--- testbench/csr_unit_tb.sv
`timescale 1ns/1ps

module csr_unit_tb;

   localparam int          CLK_HALF   = 20;
   localparam int          RESET_CYC  = 8;
   localparam int          REDIR_WAIT = 4;
   localparam int unsigned SEED       = 32'hb9b012c5;
   localparam string       DATA_FILE  = "testbench/csr_unit_testdata.txt";

   typedef struct packed {
      logic [1:0]         op;
      csr_pkg::csr_addr_t addr;
      csr_pkg::csr_data_t operand;
      csr_pkg::csr_data_t pc;
      logic               intr;
      logic               mret;
      csr_pkg::csr_data_t exp_rdata;
      logic               exp_redir;
      csr_pkg::csr_data_t exp_target;
      logic               exp_trap;
   } step_t;

   logic               clk_i;
   logic               rst_ni;
   csr_pkg::csr_req_t  csr_req_i;
   csr_pkg::csr_data_t pc_i;
   logic               e_intr_i;
   logic               mret_i;
   logic               redirect_ready_i;
   csr_pkg::csr_data_t csr_rdata_o;
   csr_pkg::redirect_t redirect_o;
   logic               redirect_valid_o;

   step_t steps[$];
   int    num_steps;
   logic  steps_loaded;
   int    transfer_count;
   int    expected_transfers;

   csr_unit_top csr_unit_top_i (
      .clk_i            (clk_i),
      .rst_ni           (rst_ni),
      .csr_req_i        (csr_req_i),
      .pc_i             (pc_i),
      .e_intr_i         (e_intr_i),
      .mret_i           (mret_i),
      .redirect_ready_i (redirect_ready_i),
      .csr_rdata_o      (csr_rdata_o),
      .redirect_o       (redirect_o),
      .redirect_valid_o (redirect_valid_o)
   );

   bind trap_redirect csr_unit_assertions csr_unit_assertions_i (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .req_i       (req_i),
      .req_valid_i (req_valid_i),
      .ready_i     (ready_i),
      .redirect_i  (redirect_o),
      .valid_i     (valid_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #CLK_HALF clk_i = ~clk_i;
   end

   // counts accepted redirects
   always @(posedge clk_i) begin
      if (!rst_ni) begin
         transfer_count <= 0;
      end else if (redirect_valid_o && redirect_ready_i) begin
         transfer_count <= transfer_count + 1;
      end
   end

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("Something failed");
      $fatal(1, "run aborted");
   endtask

   task automatic check_equal(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
         $display("Something failed");
         $fatal(1, "value check failed");
      end
   endtask

   task automatic load_steps();
      int          fd;
      int          n;
      string       line;
      logic [31:0] col [10];
      step_t       st;
      fd = $fopen(DATA_FILE, "r");
      if (fd == 0) begin
         abort_run({"cannot open stimulus file ", DATA_FILE});
      end else begin
         while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 1 && line.getc(0) != "#") begin
               n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h", col[0], col[1],
                           col[2], col[3], col[4], col[5], col[6], col[7], col[8], col[9]);
               if (n != 10) begin
                  abort_run({"malformed stimulus line: ", line});
               end else begin
                  st.op         = col[0][1:0];
                  st.addr       = csr_pkg::csr_addr_t'(col[1]);
                  st.operand    = col[2];
                  st.pc         = col[3];
                  st.intr       = col[4][0];
                  st.mret       = col[5][0];
                  st.exp_rdata  = col[6];
                  st.exp_redir  = col[7][0];
                  st.exp_target = col[8];
                  st.exp_trap   = col[9][0];
                  steps.push_back(st);
               end
            end
         end
         $fclose(fd);
      end
      num_steps = steps.size();
   endtask

   task automatic expect_quiet();
      repeat (3) begin
         @(negedge clk_i);
         check_equal("redirect_valid_o", 32'(redirect_valid_o), 32'd0);
      end
   endtask

   task automatic expect_redirect(input csr_pkg::csr_data_t target, input logic is_trap);
      int waited;
      int stall;
      waited = 0;
      expected_transfers++;
      @(negedge clk_i);
      while (!redirect_valid_o && waited < REDIR_WAIT) begin
         waited++;
         @(negedge clk_i);
      end
      if (!redirect_valid_o) begin
         abort_run("timeout: no redirect appeared after the event");
      end else begin
         check_equal("redirect_o.target", redirect_o.target, target);
         check_equal("redirect_o.is_trap", 32'(redirect_o.is_trap), 32'(is_trap));
         stall = $urandom_range(3, 0);
         repeat (stall) begin
            @(negedge clk_i);   // fetch stalls
            check_equal("redirect_valid_o", 32'(redirect_valid_o), 32'd1);
            check_equal("redirect_o.target", redirect_o.target, target);
         end
         @(posedge clk_i);
         redirect_ready_i <= 1'b1;
         @(negedge clk_i);
         check_equal("redirect_valid_o", 32'(redirect_valid_o), 32'd1);
         check_equal("redirect_o.target", redirect_o.target, target);
         @(posedge clk_i);
         redirect_ready_i <= 1'b0;   // accepted at this edge
         @(negedge clk_i);
         check_equal("redirect_valid_o", 32'(redirect_valid_o), 32'd0);
      end
   endtask

   task automatic apply_step(input step_t st);
      csr_pkg::csr_req_t req;
      req.op      = csr_pkg::csr_op_e'(st.op);
      req.addr    = st.addr;
      req.operand = st.operand;
      @(posedge clk_i);
      csr_req_i <= req;
      pc_i      <= st.pc;
      e_intr_i  <= st.intr;
      mret_i    <= st.mret;
      @(negedge clk_i);
      check_equal("csr_rdata_o", csr_rdata_o, st.exp_rdata);   // read is combinational
      @(posedge clk_i);
      csr_req_i <= '0;
      e_intr_i  <= 1'b0;
      mret_i    <= 1'b0;
      if (st.exp_redir) begin
         expect_redirect(st.exp_target, st.exp_trap);
      end else begin
         expect_quiet();
      end
   endtask

   initial begin : watchdog
      wait (steps_loaded);
      repeat (num_steps * 8 + 20) @(posedge clk_i);
      abort_run("timeout: the run exceeded its cycle budget");
   end

   initial begin : stimulus
      rst_ni             = 1'b0;
      csr_req_i          = '0;
      pc_i               = '0;
      e_intr_i           = 1'b0;
      mret_i             = 1'b0;
      redirect_ready_i   = 1'b0;
      expected_transfers = 0;
      steps_loaded       = 1'b0;
      void'($urandom(SEED));
      load_steps();
      if (num_steps == 0) begin
         abort_run("the stimulus file holds no test steps");
      end else begin
         steps_loaded = 1'b1;
         repeat (RESET_CYC) @(posedge clk_i);
         rst_ni <= 1'b1;
         @(negedge clk_i);
         check_equal("redirect_valid_o", 32'(redirect_valid_o), 32'd0);
         foreach (steps[i]) begin
            apply_step(steps[i]);
         end
         check_equal("redirect_transfers", 32'(transfer_count), 32'(expected_transfers));
         $display("Everything OK");
         $finish;
      end
   end

endmodule

//--- csr_unit.f
+incdir+rtl
rtl/csr_pkg.sv
rtl/csr_access.sv
rtl/csr_regs.sv
rtl/csr_ops.sv
rtl/trap_redirect.sv
rtl/csr_unit_top.sv
testbench/csr_unit_assertions.sv
testbench/csr_unit_tb.sv

//--- Makefile
# Verilator build for the CSR unit testbench

VERILATOR ?= verilator
TOP       ?= csr_unit_tb
FILELIST  ?= csr_unit.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard rtl/*.sv rtl/*.svh testbench/*.sv)

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# the simulator exit status is the verdict
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

//--- testbench/csr_unit_testdata.txt
# op addr operand pc intr mret | exp_rdata exp_redirect exp_target exp_is_trap
# op: 0 none, 1 rw, 2 rs, 3 rc; all columns hex
0 300 00000000 00000000 0 0 00000000 0 00000000 0
0 304 00000000 00000000 0 0 00000000 0 00000000 0
0 305 00000000 00000000 0 0 00000000 0 00000000 0
0 341 00000000 00000000 0 0 00000000 0 00000000 0
0 342 00000000 00000000 0 0 00000000 0 00000000 0
0 344 00000000 00000000 0 0 00000000 0 00000000 0
# software access to mtvec, mie, mstatus
1 305 00000100 00000000 0 0 00000000 0 00000000 0
2 305 0000000c 00000000 0 0 00000100 0 00000000 0
3 305 00000004 00000000 0 0 0000010c 0 00000000 0
0 305 00000000 00000000 0 0 00000108 0 00000000 0
1 304 00000880 00000000 0 0 00000000 0 00000000 0
3 304 00000080 00000000 0 0 00000880 0 00000000 0
2 300 00000000 00000000 0 0 00000000 0 00000000 0
1 300 00000088 00000000 0 0 00000000 0 00000000 0
3 300 00000080 00000000 0 0 00000088 0 00000000 0
# read-only registers ignore writes
1 341 deadbeef 00000000 0 0 00000000 0 00000000 0
2 342 ffffffff 00000000 0 0 00000000 0 00000000 0
1 344 00000800 00000000 0 0 00000000 0 00000000 0
0 300 00000000 00000000 0 0 00000008 0 00000000 0
0 304 00000000 00000000 0 0 00000800 0 00000000 0
0 341 00000000 00000000 0 0 00000000 0 00000000 0
0 342 00000000 00000000 0 0 00000000 0 00000000 0
0 344 00000000 00000000 0 0 00000000 0 00000000 0
# interrupt taken
0 342 00000000 00001234 1 0 00000000 1 00000108 1
0 341 00000000 00000000 0 0 00001234 0 00000000 0
0 342 00000000 00000000 0 0 8000000b 0 00000000 0
0 344 00000000 00000000 0 0 00000800 0 00000000 0
0 300 00000000 00000000 0 0 00000000 0 00000000 0
# return
0 300 00000000 00000000 0 1 00000000 1 00001234 0
0 300 00000000 00000000 0 0 00000008 0 00000000 0
0 344 00000000 00000000 0 0 00000000 0 00000000 0
# masked interrupt, then enabling it
3 304 00000800 00000000 0 0 00000800 0 00000000 0
0 341 00000000 00002000 1 0 00001234 0 00000000 0
0 341 00000000 00000000 0 0 00002000 0 00000000 0
0 344 00000000 00000000 0 0 00000800 0 00000000 0
2 304 00000800 00000000 0 0 00000000 1 00000108 1
0 300 00000000 00000000 0 0 00000000 0 00000000 0
0 300 00000000 00000000 0 1 00000000 1 00002000 0
0 344 00000000 00000000 0 0 00000000 0 00000000 0
